//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rvCore_tb
FILELIST  = project.f

BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
src/rvIsaPkg.sv
src/coreCtlPkg.sv
src/decodeIf.sv
src/instrDecoder.sv
src/regFile.sv
src/aluUnit.sv
src/branchUnit.sv
src/commitUnit.sv
src/rvCore.sv
verif/rvCore_tb.sv

//--- src/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    decodeIf.consumer        dec,
    input  coreCtlPkg::wordT rs1Data,
    input  coreCtlPkg::wordT rs2Data,
    output coreCtlPkg::wordT aluResult,
    output coreCtlPkg::wordT memAddr,
    output coreCtlPkg::wordT storeData,
    output logic             memWrite,
    output logic             memRead
);

    coreCtlPkg::wordT opB;
    logic [4:0]       shamt;

    assign opB   = dec.immSel ? dec.imm : rs2Data;
    assign shamt = opB[4:0];  // low five bits only

    always_comb begin
        case (dec.aluOp)
            coreCtlPkg::ADD:    aluResult = rs1Data + opB;
            coreCtlPkg::SUB:    aluResult = rs1Data - opB;
            coreCtlPkg::AND:    aluResult = rs1Data & opB;
            coreCtlPkg::OR:     aluResult = rs1Data | opB;
            coreCtlPkg::XOR:    aluResult = rs1Data ^ opB;
            coreCtlPkg::SLT:    aluResult = coreCtlPkg::wordT'($signed(rs1Data) < $signed(opB));
            coreCtlPkg::SLTU:   aluResult = coreCtlPkg::wordT'(rs1Data < opB);
            coreCtlPkg::SLL:    aluResult = rs1Data << shamt;
            coreCtlPkg::SRL:    aluResult = rs1Data >> shamt;
            coreCtlPkg::SRA:    aluResult = coreCtlPkg::wordT'($signed(rs1Data) >>> shamt);
            coreCtlPkg::PASS_B: aluResult = opB;
            default:            aluResult = rs1Data + opB;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // data memory request
    ////////////////////////////////////////////////////////////

    assign memAddr   = aluResult;  // rs1 + imm for lw/sw
    assign storeData = rs2Data;
    assign memWrite  = (dec.opcode == rvIsaPkg::STORE);
    assign memRead   = (dec.opcode == rvIsaPkg::LOAD);

endmodule

//--- src/branchUnit.sv
`timescale 1ns/1ps

module branchUnit (
    decodeIf.consumer        dec,
    input  coreCtlPkg::wordT rs1Data,
    input  coreCtlPkg::wordT rs2Data,
    input  coreCtlPkg::wordT pc,
    output logic             takeJump,
    output coreCtlPkg::wordT jumpTarget
);

    logic condMet;

    always_comb begin
        case (rvIsaPkg::branchCondE'(dec.funct3))
            rvIsaPkg::BEQ:  condMet = (rs1Data == rs2Data);
            rvIsaPkg::BNE:  condMet = (rs1Data != rs2Data);
            rvIsaPkg::BLT:  condMet = ($signed(rs1Data) < $signed(rs2Data));
            rvIsaPkg::BGE:  condMet = ($signed(rs1Data) >= $signed(rs2Data));
            rvIsaPkg::BLTU: condMet = (rs1Data < rs2Data);
            rvIsaPkg::BGEU: condMet = (rs1Data >= rs2Data);
            default:        condMet = 1'b0;  // reserved funct3, falls through
        endcase
    end

    assign takeJump = (dec.opcode == rvIsaPkg::JAL) ||
                      (dec.opcode == rvIsaPkg::BRANCH && condMet);

    // same adder for branch and jal offsets
    assign jumpTarget = pc + dec.imm;

endmodule

//--- src/commitUnit.sv
`timescale 1ns/1ps

module commitUnit #(
    parameter coreCtlPkg::wordT resetVector = 32'd2048
) (
    input  logic             clk,
    input  logic             rst,
    decodeIf.consumer        dec,
    input  coreCtlPkg::wordT aluResult,
    input  coreCtlPkg::wordT loadData,
    input  logic             takeJump,
    input  coreCtlPkg::wordT jumpTarget,
    output coreCtlPkg::wordT pc,
    output logic             rdWrite,
    output coreCtlPkg::wordT rdData
);

    coreCtlPkg::wordT pcNext;

    assign pcNext = pc + coreCtlPkg::INSTR_BYTES;  // also the jal link value

    ////////////////////////////////////////////////////////////
    // program counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetVector;
        end else if (takeJump) begin
            pc <= jumpTarget;
        end else begin
            pc <= pcNext;
        end
    end

    ////////////////////////////////////////////////////////////
    // write-back
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (dec.opcode)
            rvIsaPkg::OP, rvIsaPkg::OP_IMM, rvIsaPkg::LUI,
            rvIsaPkg::LOAD, rvIsaPkg::JAL: rdWrite = 1'b1;
            default:                       rdWrite = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.opcode)
            rvIsaPkg::LOAD: rdData = loadData;
            rvIsaPkg::JAL:  rdData = pcNext;
            default:        rdData = aluResult;
        endcase
    end

    // catches odd branch/jal offsets as well as a bad reset vector
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

//--- src/coreCtlPkg.sv
package coreCtlPkg;

    localparam int XLEN = 32;
    typedef logic [XLEN-1:0] wordT;

    localparam int REG_ADDR_W = 5;
    typedef logic [REG_ADDR_W-1:0] regAddrT;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        PASS_B  // lui
    } aluOpE;

    // pc step per instruction
    localparam wordT INSTR_BYTES = 32'd4;

endpackage

//--- src/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf;

    rvIsaPkg::opcodeE    opcode;
    logic [2:0]          funct3;
    coreCtlPkg::aluOpE   aluOp;
    logic                immSel;  // operand b from imm
    coreCtlPkg::regAddrT rs1;
    coreCtlPkg::regAddrT rs2;
    coreCtlPkg::regAddrT rd;
    coreCtlPkg::wordT    imm;

    modport decoder (
        output opcode, funct3, aluOp, immSel, rs1, rs2, rd, imm
    );

    modport consumer (
        input opcode, funct3, aluOp, immSel, rs1, rs2, rd, imm
    );

endinterface

//--- src/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input coreCtlPkg::wordT instr,
    decodeIf.decoder        dec
);

    logic [6:0]        opField;
    logic [2:0]        funct3;
    logic              altBit;
    coreCtlPkg::wordT  immI, immS, immB, immU, immJ;
    coreCtlPkg::aluOpE arithOp;
    coreCtlPkg::aluOpE cmpOp;

    assign opField = instr[6:0];
    assign funct3  = instr[14:12];
    assign altBit  = instr[rvIsaPkg::ALT_BIT];

    assign dec.funct3 = funct3;
    assign dec.rs1    = instr[19:15];
    assign dec.rs2    = instr[24:20];
    assign dec.rd     = instr[11:7];

    ////////////////////////////////////////////////////////////
    // immediates, all sign extended except U
    ////////////////////////////////////////////////////////////

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // op/op-imm arithmetic, SUB only exists in register form
    always_comb begin
        case (funct3)
            rvIsaPkg::F3_ADD: begin
                if (opField == rvIsaPkg::OP && altBit) arithOp = coreCtlPkg::SUB;
                else arithOp = coreCtlPkg::ADD;
            end
            rvIsaPkg::F3_SLL:  arithOp = coreCtlPkg::SLL;
            rvIsaPkg::F3_SLT:  arithOp = coreCtlPkg::SLT;
            rvIsaPkg::F3_SLTU: arithOp = coreCtlPkg::SLTU;
            rvIsaPkg::F3_XOR:  arithOp = coreCtlPkg::XOR;
            rvIsaPkg::F3_SR:   arithOp = altBit ? coreCtlPkg::SRA : coreCtlPkg::SRL;
            rvIsaPkg::F3_OR:   arithOp = coreCtlPkg::OR;
            rvIsaPkg::F3_AND:  arithOp = coreCtlPkg::AND;
            default:           arithOp = coreCtlPkg::ADD;
        endcase
    end

    // compare flavour for branches
    always_comb begin
        case (rvIsaPkg::branchCondE'(funct3))
            rvIsaPkg::BLT, rvIsaPkg::BGE:   cmpOp = coreCtlPkg::SLT;
            rvIsaPkg::BLTU, rvIsaPkg::BGEU: cmpOp = coreCtlPkg::SLTU;
            default:                        cmpOp = coreCtlPkg::SUB;  // beq/bne
        endcase
    end

    always_comb begin
        dec.opcode = rvIsaPkg::ILLEGAL;
        dec.aluOp  = coreCtlPkg::ADD;
        dec.immSel = 1'b1;
        dec.imm    = immI;
        case (opField)
            rvIsaPkg::OP: begin
                dec.opcode = rvIsaPkg::OP;
                dec.aluOp  = arithOp;
                dec.immSel = 1'b0;
            end
            rvIsaPkg::OP_IMM: begin
                dec.opcode = rvIsaPkg::OP_IMM;
                dec.aluOp  = arithOp;
            end
            rvIsaPkg::LUI: begin
                dec.opcode = rvIsaPkg::LUI;
                dec.aluOp  = coreCtlPkg::PASS_B;
                dec.imm    = immU;
            end
            rvIsaPkg::LOAD: begin
                if (funct3 == rvIsaPkg::F3_LW) dec.opcode = rvIsaPkg::LOAD;  // word only
            end
            rvIsaPkg::STORE: begin
                if (funct3 == rvIsaPkg::F3_SW) dec.opcode = rvIsaPkg::STORE;
                dec.imm = immS;
            end
            rvIsaPkg::BRANCH: begin
                dec.opcode = rvIsaPkg::BRANCH;
                dec.aluOp  = cmpOp;
                dec.immSel = 1'b0;
                dec.imm    = immB;
            end
            rvIsaPkg::JAL: begin
                dec.opcode = rvIsaPkg::JAL;
                dec.imm    = immJ;
            end
            default: ;
        endcase
    end

endmodule

//--- src/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                clk,
    input  logic                rst,
    input  coreCtlPkg::regAddrT rs1,
    input  coreCtlPkg::regAddrT rs2,
    output coreCtlPkg::wordT    rs1Data,
    output coreCtlPkg::wordT    rs2Data,
    input  logic                rdWrite,
    input  coreCtlPkg::regAddrT rd,
    input  coreCtlPkg::wordT    rdData
);

    localparam int NUM_REGS = 2 ** coreCtlPkg::REG_ADDR_W;

    coreCtlPkg::wordT regs [NUM_REGS];  // x0 cleared in reset, never written

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWrite && rd != '0) begin
            regs[rd] <= rdData;
        end
    end

    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

    assert property (@(posedge clk) disable iff (rst) (rs1 == '0) |-> (rs1Data == '0));

endmodule

//--- src/rvCore.sv
`timescale 1ns/1ps

module rvCore #(
    parameter coreCtlPkg::wordT resetVector = 32'd2048
) (
    input  logic             clk,
    input  logic             rst,
    input  coreCtlPkg::wordT instr,
    input  coreCtlPkg::wordT loadData,
    output coreCtlPkg::wordT instrAddr,
    output coreCtlPkg::wordT memAddr,
    output coreCtlPkg::wordT storeData,
    output logic             memWrite,
    output logic             memRead
);

    coreCtlPkg::wordT rs1Data, rs2Data;
    coreCtlPkg::wordT aluResult;
    coreCtlPkg::wordT jumpTarget;
    coreCtlPkg::wordT rdData;
    logic             takeJump;
    logic             rdWrite;

    decodeIf decBus ();

    instrDecoder instrDecoder_inst (
        .instr (instr),
        .dec   (decBus.decoder)
    );

    regFile regFile_inst (
        .clk     (clk),
        .rst     (rst),
        .rs1     (decBus.rs1),
        .rs2     (decBus.rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .rdWrite (rdWrite),
        .rd      (decBus.rd),
        .rdData  (rdData)
    );

    // alu and branch paths run side by side
    aluUnit aluUnit_inst (
        .dec       (decBus.consumer),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .aluResult (aluResult),
        .memAddr   (memAddr),
        .storeData (storeData),
        .memWrite  (memWrite),
        .memRead   (memRead)
    );

    branchUnit branchUnit_inst (
        .dec        (decBus.consumer),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .pc         (instrAddr),
        .takeJump   (takeJump),
        .jumpTarget (jumpTarget)
    );

    commitUnit #(
        .resetVector (resetVector)
    ) commitUnit_inst (
        .clk        (clk),
        .rst        (rst),
        .dec        (decBus.consumer),
        .aluResult  (aluResult),
        .loadData   (loadData),
        .takeJump   (takeJump),
        .jumpTarget (jumpTarget),
        .pc         (instrAddr),  // pc is the fetch address
        .rdWrite    (rdWrite),
        .rdData     (rdData)
    );

endmodule

//--- src/rvIsaPkg.sv
package rvIsaPkg;

    ////////////////////////////////////////////////////////////
    // major opcodes
    ////////////////////////////////////////////////////////////

    typedef enum logic [6:0] {
        OP      = 7'b0110011,
        OP_IMM  = 7'b0010011,
        LUI     = 7'b0110111,
        LOAD    = 7'b0000011,
        STORE   = 7'b0100011,
        BRANCH  = 7'b1100011,
        JAL     = 7'b1101111,
        ILLEGAL = 7'b0000000  // anything not kept, runs as a nop
    } opcodeE;

    // branch conditions, funct3 encoded
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branchCondE;

    ////////////////////////////////////////////////////////////
    // funct3 / funct7 fields
    ////////////////////////////////////////////////////////////

    localparam logic [2:0] F3_ADD  = 3'b000;  // also SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL / SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_LW = 3'b010;
    localparam logic [2:0] F3_SW = 3'b010;

    // instr bit 30 picks SUB over ADD and SRA over SRL
    localparam int ALT_BIT = 30;

    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

endpackage

//--- verif/rvCore_tb.sv
`timescale 1ns/1ps

module rvCore_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NAME_CHARS   = 24;
    localparam int LINE_CHARS   = 160;
    localparam coreCtlPkg::wordT RESET_VECTOR = 32'd2048;

    logic             clk;
    logic             rst;
    coreCtlPkg::wordT instr;
    coreCtlPkg::wordT loadData;
    coreCtlPkg::wordT instrAddr;
    coreCtlPkg::wordT memAddr;
    coreCtlPkg::wordT storeData;
    logic             memWrite;
    logic             memRead;

    // one entry per step of the data file
    logic [8*NAME_CHARS-1:0] stepName [$];
    coreCtlPkg::wordT        stepInstr [$];
    coreCtlPkg::wordT        stepLoad [$];
    coreCtlPkg::wordT        expAddr [$];
    coreCtlPkg::wordT        expWrite [$];
    coreCtlPkg::wordT        expRead [$];
    coreCtlPkg::wordT        expMemAddr [$];
    coreCtlPkg::wordT        expStore [$];
    int                      numSteps;
    logic                    stepsLoaded;

    rvCore #(
        .resetVector (RESET_VECTOR)
    ) rvCore_inst (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .loadData  (loadData),
        .instrAddr (instrAddr),
        .memAddr   (memAddr),
        .storeData (storeData),
        .memWrite  (memWrite),
        .memRead   (memRead)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // data file
    ////////////////////////////////////////////////////////////

    task automatic loadSteps;
        int                      fd;
        int                      fields;
        logic [8*LINE_CHARS-1:0] line;
        logic [8*NAME_CHARS-1:0] name;
        coreCtlPkg::wordT        fInstr, fLoad, fAddr, fWrite, fRead, fMemAddr, fStore;
        fd = $fopen("verif/rvCore_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file verif/rvCore_testdata.txt");
            $display("Something failed");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
                name   = '0;
                fields = $sscanf(line, "%s %h %h %h %h %h %h %h", name, fInstr, fLoad,
                                 fAddr, fWrite, fRead, fMemAddr, fStore);
                if (fields == 8 && name != "//") begin  // comment lines fail the scan
                    stepName.push_back(name);
                    stepInstr.push_back(fInstr);
                    stepLoad.push_back(fLoad);
                    expAddr.push_back(fAddr);
                    expWrite.push_back(fWrite);
                    expRead.push_back(fRead);
                    expMemAddr.push_back(fMemAddr);
                    expStore.push_back(fStore);
                end
            end
        end
        $fclose(fd);
        numSteps = stepInstr.size();
        if (numSteps == 0) begin
            $display("the test data file holds no steps");
            $display("Something failed");
            $fatal(1, "no stimulus");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic checkWord(input logic [8*NAME_CHARS-1:0] name, input string field,
                             input coreCtlPkg::wordT expected, input coreCtlPkg::wordT actual);
        assert (actual === expected) else begin
            $display("[ERROR] %0s %0s expected %h actual %h", name, field, expected, actual);
            $display("Something failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic checkStep(input int i);
        checkWord(stepName[i], "instrAddr", expAddr[i], instrAddr);
        checkWord(stepName[i], "memWrite", expWrite[i], {31'b0, memWrite});
        checkWord(stepName[i], "memRead", expRead[i], {31'b0, memRead});
        // bus values only mean something under a strobe
        if (expWrite[i] != 0 || expRead[i] != 0) begin
            checkWord(stepName[i], "memAddr", expMemAddr[i], memAddr);
        end
        if (expWrite[i] != 0) begin
            checkWord(stepName[i], "storeData", expStore[i], storeData);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        rst         = 1'b1;
        instr       = rvIsaPkg::NOP_INSTR;
        loadData    = '0;
        numSteps    = 0;
        stepsLoaded = 1'b0;
        loadSteps();
        stepsLoaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        for (int i = 0; i < numSteps; i++) begin
            @(negedge clk);
            rst      = 1'b0;
            instr    = stepInstr[i];
            loadData = stepLoad[i];
            #10;  // outputs settled, well before the next rising edge
            checkStep(i);
        end
        $display("Everything OK");
        $finish;
    end

    // watchdog
    initial begin
        wait (stepsLoaded);
        #((RESET_CYCLES + numSteps + 10) * CLK_PERIOD);
        $display("timeout, the steps did not finish in time");
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- verif/rvCore_testdata.txt
// step  instrWord  loadWord  instrAddr  memWrite  memRead  memAddr  storeWord
// x1 = -5 and x2 = 3 from the first two addi, stores use x0 as base
reset_nop   00000013 00000000 00000800 0 0 00000000 00000000
addi_neg    ffb00093 00000000 00000804 0 0 00000000 00000000
addi_pos    00300113 00000000 00000808 0 0 00000000 00000000
sub         402081b3 00000000 0000080c 0 0 00000000 00000000
sw_sub      10302023 00000000 00000810 1 0 00000100 fffffff8
slt         0020a233 00000000 00000814 0 0 00000000 00000000
sltu        0020b2b3 00000000 00000818 0 0 00000000 00000000
sw_slt      10402223 00000000 0000081c 1 0 00000104 00000001
sw_sltu     10502423 00000000 00000820 1 0 00000108 00000000
sra         4020d333 00000000 00000824 0 0 00000000 00000000
srl         0020d3b3 00000000 00000828 0 0 00000000 00000000
sw_sra      10602623 00000000 0000082c 1 0 0000010c ffffffff
sw_srl      10702823 00000000 00000830 1 0 00000110 1fffffff
xori        0f00c413 00000000 00000834 0 0 00000000 00000000
slli        00411493 00000000 00000838 0 0 00000000 00000000
or          00946533 00000000 0000083c 0 0 00000000 00000000
sw_or       10a02a23 00000000 00000840 1 0 00000114 ffffff3b
lw          20002603 a5c30f96 00000844 0 1 00000200 00000000
sw_lw       10c02c23 00000000 00000848 1 0 00000118 a5c30f96
beq_nt      00208463 00000000 0000084c 0 0 00000000 00000000
beq_t       00210463 00000000 00000850 0 0 00000000 00000000
bne_t       00209463 00000000 00000858 0 0 00000000 00000000
bne_nt      00211463 00000000 00000860 0 0 00000000 00000000
blt_t       0020c463 00000000 00000864 0 0 00000000 00000000
blt_nt      00114463 00000000 0000086c 0 0 00000000 00000000
bge_t       00115463 00000000 00000870 0 0 00000000 00000000
bge_nt      0020d463 00000000 00000878 0 0 00000000 00000000
bltu_t      00116463 00000000 0000087c 0 0 00000000 00000000
bltu_nt     0020e463 00000000 00000884 0 0 00000000 00000000
bgeu_t      0020f463 00000000 00000888 0 0 00000000 00000000
bgeu_nt     00117463 00000000 00000890 0 0 00000000 00000000
jal         010006ef 00000000 00000894 0 0 00000000 00000000
sw_link     10d02e23 00000000 000008a4 1 0 0000011c 00000898
addi_x0     05500013 00000000 000008a8 0 0 00000000 00000000
sw_x0       12002023 00000000 000008ac 1 0 00000120 00000000
lui         12345737 00000000 000008b0 0 0 00000000 00000000
sw_lui      12e02223 00000000 000008b4 1 0 00000124 12345000
